// ==== Makefile ====
# Verilator build and run of the flight control testbench
# Any variable below can be overridden on the command line

VERILATOR       ?= verilator
TOP             ?= drone_ctrl_tb
FILELIST        ?= drone_ctrl.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ns
SIM_ARGS        ?=
PASS_TEXT       := Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VERILATOR_FLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== drone_ctrl.f ====
+incdir+include
source/drone_pkg.sv
source/us_tick.sv
source/rc_receiver.sv
source/angle_controller.sv
source/motor_mixer.sv
source/pwm_generator.sv
source/drone_ctrl.sv
verification/drone_ctrl_chk.sv
verification/drone_ctrl_tb.sv

// ==== include/drone_defines.svh ====
// Shared constants for the quadcopter flight control datapath
// Included by the RTL and the testbench wherever a timing or limit value is needed
// Change US_TICK_DIV to match a different sys_clk frequency
`ifndef DRONE_DEFINES_SVH
`define DRONE_DEFINES_SVH

// sys_clk cycles per microsecond, 25 suits a 40 ns clock
`define US_TICK_DIV 25

// Valid RC receiver pulse width limits in microseconds
`define RC_MIN_US 1000
`define RC_MAX_US 2000

// Scaled stick value at center position
`define RC_CENTER 125

// Largest motor rate, maps to a 2000 us ESC pulse
`define MOTOR_MAX 250

// Saturation limit for the roll, pitch and yaw rate commands
`define AXIS_RATE_MAX 250

// ESC frame length in microseconds (50 Hz)
`define PWM_FRAME_US 20000

`endif

// ==== source/angle_controller.sv ====
// Angle controller stage of the flight pipeline
// On each IMU sample it centers the stick targets, subtracts the measured
// roll and pitch angles and saturates the results to +/-250
// Outputs load on imu_valid and ac_valid follows one cycle later
`include "drone_defines.svh"

module angle_controller (
	input  logic                  sys_clk,
	input  logic                  resetn,
	input  logic                  imu_valid,
	input  drone_pkg::rc_val_t    throttle_val,
	input  drone_pkg::rc_val_t    roll_val,
	input  drone_pkg::rc_val_t    pitch_val,
	input  drone_pkg::rc_val_t    yaw_val,
	input  drone_pkg::angle_t     roll_angle,
	input  drone_pkg::angle_t     pitch_angle,
	output drone_pkg::rc_val_t    throttle_rate,
	output drone_pkg::axis_rate_t roll_rate,
	output drone_pkg::axis_rate_t pitch_rate,
	output drone_pkg::axis_rate_t yaw_rate,
	output logic                  ac_valid
);

	import drone_pkg::*;

	localparam logic signed [11:0] CENTER = `RC_CENTER;

	logic signed [11:0] roll_tgt;
	logic signed [11:0] pitch_tgt;
	logic signed [11:0] yaw_tgt;
	logic signed [11:0] roll_err;
	logic signed [11:0] pitch_err;

	// Limit a wide signed value to the axis rate range
	function automatic axis_rate_t sat_rate(input logic signed [11:0] value);
		if (value > `AXIS_RATE_MAX) begin
			return axis_rate_t'(`AXIS_RATE_MAX);
		end else if (value < -`AXIS_RATE_MAX) begin
			return axis_rate_t'(-`AXIS_RATE_MAX);
		end
		return value[9:0];
	endfunction

	// Stick targets from -125 to 125 around center
	assign roll_tgt  = $signed({4'b0000, roll_val}) - CENTER;
	assign pitch_tgt = $signed({4'b0000, pitch_val}) - CENTER;
	assign yaw_tgt   = $signed({4'b0000, yaw_val}) - CENTER;

	// 12 bits hold the full -636..637 angle error span
	assign roll_err  = roll_tgt - 12'(roll_angle);
	assign pitch_err = pitch_tgt - 12'(pitch_angle);

	// Rate payload loads on each sample
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			throttle_rate <= '0;
			roll_rate     <= '0;
			pitch_rate    <= '0;
			yaw_rate      <= '0;
		end else if (imu_valid) begin
			throttle_rate <= throttle_val;
			roll_rate     <= sat_rate(roll_err);
			pitch_rate    <= sat_rate(pitch_err);
			// Yaw has no angle term here
			yaw_rate      <= sat_rate(yaw_tgt);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			ac_valid <= 1'b0;
		end else begin
			ac_valid <= imu_valid;
		end
	end

endmodule

// ==== source/drone_ctrl.sv ====
// Top level of the quadcopter flight control datapath
// RC pulses and IMU attitude samples go in; four ESC pulses and the motor
// rates (telemetry) come out
// Pipeline: rc_receiver and IMU -> angle_controller -> motor_mixer -> pwm_generator
module drone_ctrl (
	input  logic                   sys_clk,
	input  logic                   resetn,
	input  logic                   throttle_pwm,
	input  logic                   roll_pwm,
	input  logic                   pitch_pwm,
	input  logic                   yaw_pwm,
	input  logic                   imu_valid,
	input  drone_pkg::angle_t      roll_angle,
	input  drone_pkg::angle_t      pitch_angle,
	output drone_pkg::motor_rate_t motor_1_rate,
	output drone_pkg::motor_rate_t motor_2_rate,
	output drone_pkg::motor_rate_t motor_3_rate,
	output drone_pkg::motor_rate_t motor_4_rate,
	output logic                   mixer_valid,
	output logic                   motor_1_pwm,
	output logic                   motor_2_pwm,
	output logic                   motor_3_pwm,
	output logic                   motor_4_pwm
);

	import drone_pkg::*;

	// Time base
	logic us_pulse;

	// Scaled stick values
	rc_val_t throttle_val;
	rc_val_t roll_val;
	rc_val_t pitch_val;
	rc_val_t yaw_val;

	// Angle controller to mixer
	rc_val_t    throttle_rate;
	axis_rate_t roll_rate;
	axis_rate_t pitch_rate;
	axis_rate_t yaw_rate;
	logic       ac_valid;

	us_tick i_us_tick (
		.sys_clk  (sys_clk),
		.resetn   (resetn),
		.us_pulse (us_pulse)
	);

	rc_receiver i_rc_receiver (
		.sys_clk      (sys_clk),
		.resetn       (resetn),
		.us_pulse     (us_pulse),
		.throttle_pwm (throttle_pwm),
		.roll_pwm     (roll_pwm),
		.pitch_pwm    (pitch_pwm),
		.yaw_pwm      (yaw_pwm),
		.throttle_val (throttle_val),
		.roll_val     (roll_val),
		.pitch_val    (pitch_val),
		.yaw_val      (yaw_val)
	);

	// Runs once per IMU sample
	angle_controller i_angle_controller (
		.sys_clk       (sys_clk),
		.resetn        (resetn),
		.imu_valid     (imu_valid),
		.throttle_val  (throttle_val),
		.roll_val      (roll_val),
		.pitch_val     (pitch_val),
		.yaw_val       (yaw_val),
		.roll_angle    (roll_angle),
		.pitch_angle   (pitch_angle),
		.throttle_rate (throttle_rate),
		.roll_rate     (roll_rate),
		.pitch_rate    (pitch_rate),
		.yaw_rate      (yaw_rate),
		.ac_valid      (ac_valid)
	);

	motor_mixer i_motor_mixer (
		.sys_clk       (sys_clk),
		.resetn        (resetn),
		.ac_valid      (ac_valid),
		.throttle_rate (throttle_rate),
		.roll_rate     (roll_rate),
		.pitch_rate    (pitch_rate),
		.yaw_rate      (yaw_rate),
		.motor_1_rate  (motor_1_rate),
		.motor_2_rate  (motor_2_rate),
		.motor_3_rate  (motor_3_rate),
		.motor_4_rate  (motor_4_rate),
		.mixer_valid   (mixer_valid)
	);

	// New rates take effect at the next frame start
	pwm_generator i_pwm_generator (
		.sys_clk      (sys_clk),
		.resetn       (resetn),
		.us_pulse     (us_pulse),
		.motor_1_rate (motor_1_rate),
		.motor_2_rate (motor_2_rate),
		.motor_3_rate (motor_3_rate),
		.motor_4_rate (motor_4_rate),
		.motor_1_pwm  (motor_1_pwm),
		.motor_2_pwm  (motor_2_pwm),
		.motor_3_pwm  (motor_3_pwm),
		.motor_4_pwm  (motor_4_pwm)
	);

endmodule

// ==== source/drone_pkg.sv ====
// Data types shared across the flight control datapath
// Each width that carries a meaning gets its own typedef
// Modules import this package inside their bodies and use scoped names on ports
package drone_pkg;

	// Scaled stick value, 0 to 250
	typedef logic [7:0] rc_val_t;

	// IMU attitude angle in degrees
	typedef logic signed [9:0] angle_t;

	// Axis rate command, saturated to +/-250
	typedef logic signed [9:0] axis_rate_t;

	// Motor rate, 0 to 250
	typedef logic [7:0] motor_rate_t;

	// Microsecond count for RC pulse measurement
	// Wide enough for out-of-range pulses beyond 2000 us
	typedef logic [11:0] pulse_us_t;

endpackage

// ==== source/motor_mixer.sv ====
// X-frame motor mixer
// Halves each axis rate, forms the four motor sums around throttle and
// clamps them to 0..MOTOR_MAX; results load on ac_valid
// mixer_valid marks the cycle in which new motor rates appear
`include "drone_defines.svh"

module motor_mixer (
	input  logic                   sys_clk,
	input  logic                   resetn,
	input  logic                   ac_valid,
	input  drone_pkg::rc_val_t     throttle_rate,
	input  drone_pkg::axis_rate_t  roll_rate,
	input  drone_pkg::axis_rate_t  pitch_rate,
	input  drone_pkg::axis_rate_t  yaw_rate,
	output drone_pkg::motor_rate_t motor_1_rate,
	output drone_pkg::motor_rate_t motor_2_rate,
	output drone_pkg::motor_rate_t motor_3_rate,
	output drone_pkg::motor_rate_t motor_4_rate,
	output logic                   mixer_valid
);

	import drone_pkg::*;

	logic signed [11:0] thr_ext;
	logic signed [11:0] roll_half;
	logic signed [11:0] pitch_half;
	logic signed [11:0] yaw_half;
	logic signed [11:0] sum_1;
	logic signed [11:0] sum_2;
	logic signed [11:0] sum_3;
	logic signed [11:0] sum_4;

	// Bring a motor sum back into the 0..MOTOR_MAX range
	function automatic motor_rate_t clamp_motor(input logic signed [11:0] value);
		if (value < 0) begin
			return '0;
		end else if (value > `MOTOR_MAX) begin
			return motor_rate_t'(`MOTOR_MAX);
		end
		return value[7:0];
	endfunction

	assign thr_ext = $signed({4'b0000, throttle_rate});

	// Arithmetic shift, rounds toward minus infinity
	assign roll_half  = 12'(roll_rate >>> 1);
	assign pitch_half = 12'(pitch_rate >>> 1);
	assign yaw_half   = 12'(yaw_rate >>> 1);

	// X-frame mix, worst case -375..625 fits 12 bits signed
	assign sum_1 = thr_ext + pitch_half + roll_half - yaw_half;
	assign sum_2 = thr_ext + pitch_half - roll_half + yaw_half;
	assign sum_3 = thr_ext - pitch_half - roll_half - yaw_half;
	assign sum_4 = thr_ext - pitch_half + roll_half + yaw_half;

	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			motor_1_rate <= '0;
			motor_2_rate <= '0;
			motor_3_rate <= '0;
			motor_4_rate <= '0;
			mixer_valid  <= 1'b0;
		end else begin
			mixer_valid <= ac_valid;
			if (ac_valid) begin
				motor_1_rate <= clamp_motor(sum_1);
				motor_2_rate <= clamp_motor(sum_2);
				motor_3_rate <= clamp_motor(sum_3);
				motor_4_rate <= clamp_motor(sum_4);
			end
		end
	end

endmodule

// ==== source/pwm_generator.sv ====
// ESC pulse generator for the four motors
// A microsecond frame counter runs over PWM_FRAME_US; the motor rates are
// latched at frame start and each output is high for 1000 + 4 * rate us
// The first frame starts on the first us_pulse after reset
`include "drone_defines.svh"

module pwm_generator (
	input  logic                   sys_clk,
	input  logic                   resetn,
	input  logic                   us_pulse,
	input  drone_pkg::motor_rate_t motor_1_rate,
	input  drone_pkg::motor_rate_t motor_2_rate,
	input  drone_pkg::motor_rate_t motor_3_rate,
	input  drone_pkg::motor_rate_t motor_4_rate,
	output logic                   motor_1_pwm,
	output logic                   motor_2_pwm,
	output logic                   motor_3_pwm,
	output logic                   motor_4_pwm
);

	import drone_pkg::*;

	localparam int NUM_MOTORS = 4;
	localparam int FRAME_W    = $clog2(`PWM_FRAME_US);

	logic [FRAME_W-1:0]    frame_cnt;
	logic                  frame_start;
	motor_rate_t           rate_in [NUM_MOTORS];
	logic [NUM_MOTORS-1:0] pwm_out;

	assign rate_in[0] = motor_1_rate;
	assign rate_in[1] = motor_2_rate;
	assign rate_in[2] = motor_3_rate;
	assign rate_in[3] = motor_4_rate;

	// Last microsecond of the frame, next count is 0
	assign frame_start = us_pulse && (frame_cnt == FRAME_W'(`PWM_FRAME_US - 1));

	// Reset parks the counter at the frame end
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			frame_cnt <= FRAME_W'(`PWM_FRAME_US - 1);
		end else if (frame_start) begin
			frame_cnt <= '0;
		end else if (us_pulse) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_motor
		motor_rate_t        rate_q;
		logic [FRAME_W-1:0] pulse_len;
		logic               pwm_q;

		// 1000..2000 us
		assign pulse_len = FRAME_W'(`RC_MIN_US) + FRAME_W'({rate_q, 2'b00});

		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				rate_q <= '0;
				pwm_q  <= 1'b0;
			end else begin
				if (frame_start) begin
					rate_q <= rate_in[m];
				end
				// Registered compare keeps the ESC line glitch free
				pwm_q <= (frame_cnt < pulse_len);
			end
		end

		assign pwm_out[m] = pwm_q;
	end

	assign motor_1_pwm = pwm_out[0];
	assign motor_2_pwm = pwm_out[1];
	assign motor_3_pwm = pwm_out[2];
	assign motor_4_pwm = pwm_out[3];

endmodule

// ==== source/rc_receiver.sv ====
// Four-channel RC receiver front end
// Measures the high time of each receiver pulse in microseconds and scales
// it from the 1000..2000 us range to a stick value of 0..250
// Each value updates on the falling edge of its pulse and holds until the next
`include "drone_defines.svh"

module rc_receiver (
	input  logic              sys_clk,
	input  logic              resetn,
	input  logic              us_pulse,
	input  logic              throttle_pwm,
	input  logic              roll_pwm,
	input  logic              pitch_pwm,
	input  logic              yaw_pwm,
	output drone_pkg::rc_val_t throttle_val,
	output drone_pkg::rc_val_t roll_val,
	output drone_pkg::rc_val_t pitch_val,
	output drone_pkg::rc_val_t yaw_val
);

	import drone_pkg::*;

	localparam int NUM_CH = 4;

	// Channel order: throttle, roll, pitch, yaw
	logic [NUM_CH-1:0] pwm_in;
	rc_val_t           chan_val [NUM_CH];

	assign pwm_in = {yaw_pwm, pitch_pwm, roll_pwm, throttle_pwm};

	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chan
		logic      sync_1;
		logic      sync_2;
		logic      level_q;
		logic      rise;
		logic      fall;
		pulse_us_t width_cnt;
		pulse_us_t clamped;
		pulse_us_t span;
		rc_val_t   val_q;

		// Edges seen on the synchronized level
		assign rise = sync_2 & ~level_q;
		assign fall = ~sync_2 & level_q;

		// Clamp the measured width to the valid stick range
		always_comb begin
			if (width_cnt < pulse_us_t'(`RC_MIN_US)) begin
				clamped = pulse_us_t'(`RC_MIN_US);
			end else if (width_cnt > pulse_us_t'(`RC_MAX_US)) begin
				clamped = pulse_us_t'(`RC_MAX_US);
			end else begin
				clamped = width_cnt;
			end
		end

		// 0..1000 us above minimum
		assign span = clamped - pulse_us_t'(`RC_MIN_US);

		always_ff @(posedge sys_clk) begin
			if (!resetn) begin
				sync_1    <= 1'b0;
				sync_2    <= 1'b0;
				level_q   <= 1'b0;
				width_cnt <= '0;
				val_q     <= '0;
			end else begin
				// Two-flop synchronizer, then a delayed copy for edges
				sync_1  <= pwm_in[ch];
				sync_2  <= sync_1;
				level_q <= sync_2;

				// Count microseconds while high, stick at full scale
				if (rise) begin
					width_cnt <= '0;
				end else if (sync_2 && us_pulse && width_cnt != '1) begin
					width_cnt <= width_cnt + 1'b1;
				end

				// Divide by 4, remainder dropped
				if (fall) begin
					val_q <= span[9:2];
				end
			end
		end

		assign chan_val[ch] = val_q;
	end

	assign throttle_val = chan_val[0];
	assign roll_val     = chan_val[1];
	assign pitch_val    = chan_val[2];
	assign yaw_val      = chan_val[3];

endmodule

// ==== source/us_tick.sv ====
// Microsecond time base for the receiver and the ESC pulse generator
// Emits a one-cycle us_pulse every US_TICK_DIV sys_clk cycles
`include "drone_defines.svh"

module us_tick (
	input  logic sys_clk,
	input  logic resetn,
	output logic us_pulse
);

	localparam int CNT_W = $clog2(`US_TICK_DIV);

	logic [CNT_W-1:0] div_cnt;

	// Modulo counter, pulse registered on the wrap cycle
	always_ff @(posedge sys_clk) begin
		if (!resetn) begin
			div_cnt  <= '0;
			us_pulse <= 1'b0;
		end else if (div_cnt == CNT_W'(`US_TICK_DIV - 1)) begin
			div_cnt  <= '0;
			us_pulse <= 1'b1;
		end else begin
			div_cnt  <= div_cnt + 1'b1;
			us_pulse <= 1'b0;
		end
	end

endmodule

// ==== verification/drone_ctrl_chk.sv ====
// Concurrent checks on the flight control top level, attached with bind
// Covers the mixer strobe timing, the motor rate range, the ESC pulse
// length and quiet strobes while reset is held
`include "drone_defines.svh"

module drone_ctrl_chk (
	input logic                   sys_clk,
	input logic                   resetn,
	input logic                   us_pulse,
	input logic                   ac_valid,
	input logic                   mixer_valid,
	input drone_pkg::motor_rate_t motor_1_rate,
	input drone_pkg::motor_rate_t motor_2_rate,
	input drone_pkg::motor_rate_t motor_3_rate,
	input drone_pkg::motor_rate_t motor_4_rate,
	input logic                   motor_1_pwm,
	input logic                   motor_2_pwm,
	input logic                   motor_3_pwm,
	input logic                   motor_4_pwm
);

	timeunit 1ns;
	timeprecision 1ns;

	// Longest legal ESC pulse in sys_clk cycles
	localparam int PWM_LIMIT = `RC_MAX_US * `US_TICK_DIV;

	logic [3:0] pwm;
	int         high_cnt [4];
	// Count of failed assertions
	int         fail_cnt = 0;

	assign pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	// Running high time per ESC line
	always_ff @(posedge sys_clk) begin
		for (int m = 0; m < 4; m++) begin
			if (!resetn || !pwm[m]) begin
				high_cnt[m] <= 0;
			end else begin
				high_cnt[m] <= high_cnt[m] + 1;
			end
		end
	end

	// Mixer answers each controller strobe one cycle later
	a_mix_follows: assert property (@(posedge sys_clk) disable iff (!resetn)
		ac_valid |=> mixer_valid)
		else begin
			$error("mixer_valid missing one cycle after ac_valid");
			fail_cnt++;
		end

	a_rate_range: assert property (@(posedge sys_clk) disable iff (!resetn)
		motor_1_rate <= `MOTOR_MAX && motor_2_rate <= `MOTOR_MAX &&
		motor_3_rate <= `MOTOR_MAX && motor_4_rate <= `MOTOR_MAX)
		else begin
			$error("motor rate above MOTOR_MAX");
			fail_cnt++;
		end

	a_pwm_len: assert property (@(posedge sys_clk) disable iff (!resetn)
		high_cnt[0] <= PWM_LIMIT && high_cnt[1] <= PWM_LIMIT &&
		high_cnt[2] <= PWM_LIMIT && high_cnt[3] <= PWM_LIMIT)
		else begin
			$error("ESC pulse longer than the 2000 us maximum");
			fail_cnt++;
		end

	// Flops have seen one reset edge by the second cycle
	a_reset_quiet: assert property (@(posedge sys_clk)
		(!resetn && $past(!resetn)) |-> (!us_pulse && !ac_valid && !mixer_valid))
		else begin
			$error("strobe active during reset");
			fail_cnt++;
		end

endmodule

bind drone_ctrl drone_ctrl_chk i_chk (
	.sys_clk      (sys_clk),
	.resetn       (resetn),
	.us_pulse     (us_pulse),
	.ac_valid     (ac_valid),
	.mixer_valid  (mixer_valid),
	.motor_1_rate (motor_1_rate),
	.motor_2_rate (motor_2_rate),
	.motor_3_rate (motor_3_rate),
	.motor_4_rate (motor_4_rate),
	.motor_1_pwm  (motor_1_pwm),
	.motor_2_pwm  (motor_2_pwm),
	.motor_3_pwm  (motor_3_pwm),
	.motor_4_pwm  (motor_4_pwm)
);

// ==== verification/drone_ctrl_tb.sv ====
// Testbench for the quadcopter flight control datapath
// Plays a table of RC pulse widths and IMU angles into the DUT and checks the
// scaled sticks, the motor rates two cycles after each IMU sample and, on
// marked rows, the ESC pulse widths of the next frame
// Expected values come from the receiver scaling and X-frame mix rules
`include "drone_defines.svh"

module drone_ctrl_tb;

	timeunit 1ns;
	timeprecision 1ns;

	import drone_pkg::*;

	localparam int NUM_FIXED = 6;
	localparam int NUM_ROWS  = 10;
	// Two frames plus four full-width pulses per row plus slack
	localparam int MAX_CYCLES =
		NUM_ROWS * (2 * `PWM_FRAME_US + 4 * `RC_MAX_US) * `US_TICK_DIV + 100000;

	logic        sys_clk;
	logic        resetn;
	logic        throttle_pwm;
	logic        roll_pwm;
	logic        pitch_pwm;
	logic        yaw_pwm;
	logic        imu_valid;
	angle_t      roll_angle;
	angle_t      pitch_angle;
	motor_rate_t motor_1_rate;
	motor_rate_t motor_2_rate;
	motor_rate_t motor_3_rate;
	motor_rate_t motor_4_rate;
	logic        mixer_valid;
	logic        motor_1_pwm;
	logic        motor_2_pwm;
	logic        motor_3_pwm;
	logic        motor_4_pwm;

	// Stimulus widths in us for throttle, roll, pitch and yaw
	int pw_tab    [NUM_ROWS][4];
	int ra_tab    [NUM_ROWS];
	int pa_tab    [NUM_ROWS];
	bit pwm_row   [NUM_ROWS];
	// Expected stick values and motor rates
	int val_exp   [NUM_ROWS][4];
	int motor_exp [NUM_ROWS][4];

	int seed;
	int cycle_cnt;
	int row_errors;
	int total_errors;
	int tests_run;
	int tests_failed;

	drone_ctrl i_dut (.*);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// Watchdog
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < MAX_CYCLES) begin
			@(posedge sys_clk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	function automatic int limit_range(input int value, input int lo, input int hi);
		if (value < lo) begin
			return lo;
		end else if (value > hi) begin
			return hi;
		end
		return value;
	endfunction

	// Clamp to the RC limits, remove the offset and drop the remainder
	function automatic int scale_width(input int width);
		return (limit_range(width, `RC_MIN_US, `RC_MAX_US) - `RC_MIN_US) / 4;
	endfunction

	// Rate of motor idx (1..4) from stick values and IMU angles
	function automatic int mix_motor(input int idx, input int thr, input int roll,
		input int pitch, input int yaw, input int ra, input int pa);
		int roll_h;
		int pitch_h;
		int yaw_h;
		int sum;
		roll_h  = limit_range(roll - `RC_CENTER - ra, -`AXIS_RATE_MAX, `AXIS_RATE_MAX) >>> 1;
		pitch_h = limit_range(pitch - `RC_CENTER - pa, -`AXIS_RATE_MAX, `AXIS_RATE_MAX) >>> 1;
		yaw_h   = limit_range(yaw - `RC_CENTER, -`AXIS_RATE_MAX, `AXIS_RATE_MAX) >>> 1;
		case (idx)
			1: sum = thr + pitch_h + roll_h - yaw_h;
			2: sum = thr + pitch_h - roll_h + yaw_h;
			3: sum = thr - pitch_h - roll_h - yaw_h;
			default: sum = thr - pitch_h + roll_h + yaw_h;
		endcase
		return limit_range(sum, 0, `MOTOR_MAX);
	endfunction

	task automatic set_row(input int row, input int t, input int r, input int p, input int y,
		input int ra, input int pa, input bit pwm);
		pw_tab[row] = '{t, r, p, y};
		ra_tab[row]  = ra;
		pa_tab[row]  = pa;
		pwm_row[row] = pwm;
	endtask

	// Widths are 2 mod 4 so a count one short scales the same
	task automatic build_table();
		int row;
		int ch;
		int k;
		set_row(0, 1502, 1502, 1502, 1502, 0, 0, 1'b0);
		set_row(1, 1302, 1602, 1402, 1702, 10, -20, 1'b1);
		// Full sticks against large angles so motor 4 clamps at 250
		set_row(2, 1998, 1998, 998, 1998, -300, 300, 1'b1);
		// Opposite corner where motor 4 clamps at 0
		set_row(3, 998, 998, 1998, 998, 200, -200, 1'b0);
		// Out of range pulses read as 1000 and 2000 us
		set_row(4, 2300, 800, 2300, 800, 0, 0, 1'b0);
		set_row(5, 1702, 1502, 1502, 1502, 511, -512, 1'b0);
		for (row = NUM_FIXED; row < NUM_ROWS; row++) begin
			for (ch = 0; ch < 4; ch++) begin
				k = $random(seed) % 250;
				pw_tab[row][ch] = `RC_MIN_US + 4 * (k < 0 ? -k : k) + 2;
			end
			ra_tab[row]  = $random(seed) % 300;
			pa_tab[row]  = $random(seed) % 300;
			pwm_row[row] = 1'b0;
		end
		for (row = 0; row < NUM_ROWS; row++) begin
			for (ch = 0; ch < 4; ch++) begin
				val_exp[row][ch] = scale_width(pw_tab[row][ch]);
			end
			for (ch = 0; ch < 4; ch++) begin
				motor_exp[row][ch] = mix_motor(ch + 1, val_exp[row][0], val_exp[row][1],
					val_exp[row][2], val_exp[row][3], ra_tab[row], pa_tab[row]);
			end
		end
	endtask

	task automatic compare_value(input string name, input int got, input int want);
		if (got != want) begin
			$display("mismatch at %0t ns: %s expected %0d, got %0d", $time, name, want, got);
			row_errors++;
		end
	endtask

	task automatic verify_motors(input int want [4]);
		compare_value("motor_1_rate", int'(motor_1_rate), want[0]);
		compare_value("motor_2_rate", int'(motor_2_rate), want[1]);
		compare_value("motor_3_rate", int'(motor_3_rate), want[2]);
		compare_value("motor_4_rate", int'(motor_4_rate), want[3]);
	endtask

	// Rates and strobe idle and ESC lines low until the first frame
	task automatic idle_after_reset();
		int n;
		for (n = 0; n < `US_TICK_DIV - 5; n++) begin
			@(negedge sys_clk);
			compare_value("mixer_valid", int'(mixer_valid), 0);
			verify_motors('{0, 0, 0, 0});
			compare_value("motor_1_pwm", int'(motor_1_pwm), 0);
			compare_value("motor_2_pwm", int'(motor_2_pwm), 0);
			compare_value("motor_3_pwm", int'(motor_3_pwm), 0);
			compare_value("motor_4_pwm", int'(motor_4_pwm), 0);
		end
		n = 0;
		while (motor_1_pwm !== 1'b1 && n < 4 * `US_TICK_DIV) begin
			@(negedge sys_clk);
			n++;
		end
		if (motor_1_pwm !== 1'b1) begin
			$display("error at %0t ns: the first PWM frame never started", $time);
			row_errors++;
		end
	endtask

	// All four pulses rise together and fall at their own widths
	task automatic drive_pulses(input int row);
		int t;
		int ch;
		int len;
		len = 0;
		for (ch = 0; ch < 4; ch++) begin
			if (pw_tab[row][ch] > len) begin
				len = pw_tab[row][ch];
			end
		end
		for (t = 0; t <= len * `US_TICK_DIV; t++) begin
			@(negedge sys_clk);
			throttle_pwm = (t < pw_tab[row][0] * `US_TICK_DIV);
			roll_pwm     = (t < pw_tab[row][1] * `US_TICK_DIV);
			pitch_pwm    = (t < pw_tab[row][2] * `US_TICK_DIV);
			yaw_pwm      = (t < pw_tab[row][3] * `US_TICK_DIV);
		end
	endtask

	// High time of each ESC line in the first frame that carries the new rates
	task automatic measure_pwm(input int row);
		logic       prev;
		logic [3:0] pwm_now;
		int         high_cnt [4];
		int         m;
		int         want;
		// A frame started in the update cycle still has the old rates
		@(negedge sys_clk);
		prev = motor_1_pwm;
		@(negedge sys_clk);
		while (prev || !motor_1_pwm) begin
			prev = motor_1_pwm;
			@(negedge sys_clk);
		end
		high_cnt = '{0, 0, 0, 0};
		pwm_now  = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
		while (pwm_now != 4'b0000) begin
			for (m = 0; m < 4; m++) begin
				if (pwm_now[m]) begin
					high_cnt[m]++;
				end
			end
			@(negedge sys_clk);
			pwm_now = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};
		end
		// One microsecond either way is allowed
		for (m = 0; m < 4; m++) begin
			want = (`RC_MIN_US + 4 * motor_exp[row][m]) * `US_TICK_DIV;
			if (high_cnt[m] < want - `US_TICK_DIV || high_cnt[m] > want + `US_TICK_DIV) begin
				$display("mismatch at %0t ns: motor_%0d_pwm high cycles expected %0d, got %0d",
					$time, m + 1, want, high_cnt[m]);
				row_errors++;
			end
		end
	endtask

	task automatic run_row(input int row);
		drive_pulses(row);
		// Synchronizer and value register take 3 to 4 cycles
		repeat (6) @(negedge sys_clk);
		compare_value("throttle_val", int'(i_dut.throttle_val), val_exp[row][0]);
		compare_value("roll_val", int'(i_dut.roll_val), val_exp[row][1]);
		compare_value("pitch_val", int'(i_dut.pitch_val), val_exp[row][2]);
		compare_value("yaw_val", int'(i_dut.yaw_val), val_exp[row][3]);
		roll_angle  = angle_t'(ra_tab[row]);
		pitch_angle = angle_t'(pa_tab[row]);
		imu_valid   = 1'b1;
		@(negedge sys_clk);
		imu_valid = 1'b0;
		compare_value("mixer_valid", int'(mixer_valid), 0);
		// Exactly two cycles after the sample
		@(negedge sys_clk);
		compare_value("mixer_valid", int'(mixer_valid), 1);
		verify_motors(motor_exp[row]);
		if (pwm_row[row]) begin
			measure_pwm(row);
		end
	endtask

	// Two samples in flight with the sticks held from the last row
	task automatic back_to_back_imu();
		int last;
		int m;
		int exp_a [4];
		int exp_b [4];
		last = NUM_ROWS - 1;
		for (m = 0; m < 4; m++) begin
			exp_a[m] = mix_motor(m + 1, val_exp[last][0], val_exp[last][1],
				val_exp[last][2], val_exp[last][3], 40, -60);
			exp_b[m] = mix_motor(m + 1, val_exp[last][0], val_exp[last][1],
				val_exp[last][2], val_exp[last][3], -90, 15);
		end
		@(negedge sys_clk);
		roll_angle  = angle_t'(40);
		pitch_angle = angle_t'(-60);
		imu_valid   = 1'b1;
		@(negedge sys_clk);
		compare_value("mixer_valid", int'(mixer_valid), 0);
		roll_angle  = angle_t'(-90);
		pitch_angle = angle_t'(15);
		@(negedge sys_clk);
		imu_valid = 1'b0;
		compare_value("mixer_valid", int'(mixer_valid), 1);
		verify_motors(exp_a);
		@(negedge sys_clk);
		compare_value("mixer_valid", int'(mixer_valid), 1);
		verify_motors(exp_b);
		@(negedge sys_clk);
		compare_value("mixer_valid", int'(mixer_valid), 0);
	endtask

	task automatic report_test(input string name);
		tests_run++;
		if (row_errors == 0) begin
			$display("test %s: pass", name);
		end else begin
			$display("test %s: failed with %0d errors", name, row_errors);
			tests_failed++;
		end
		total_errors += row_errors;
		row_errors = 0;
	endtask

	initial begin
		int row;
		seed         = 31;
		resetn       = 1'b0;
		throttle_pwm = 1'b0;
		roll_pwm     = 1'b0;
		pitch_pwm    = 1'b0;
		yaw_pwm      = 1'b0;
		imu_valid    = 1'b0;
		roll_angle   = '0;
		pitch_angle  = '0;
		row_errors   = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		build_table();
		repeat (4) @(negedge sys_clk);
		resetn = 1'b1;
		idle_after_reset();
		report_test("reset state");
		for (row = 0; row < NUM_ROWS; row++) begin
			run_row(row);
			report_test($sformatf("row %0d", row));
		end
		back_to_back_imu();
		report_test("back-to-back imu_valid");
		if (i_dut.i_chk.fail_cnt != 0) begin
			$display("error: the bound checker reported %0d assertion failures",
				i_dut.i_chk.fail_cnt);
			total_errors += i_dut.i_chk.fail_cnt;
		end
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
